// File: src.f
+incdir+include
rtl/fmaPkg.sv
rtl/fmaIfs.sv
rtl/lzc.sv
rtl/fmaLza.sv
rtl/sumStage.sv
rtl/normShift.sv
rtl/fmaSumNorm.sv
bench/fmaSumNormTb.sv

// File: bench/fmaSumNormTb.sv
// FMA sum and normalize testbench
// Seeded random operands checked against a reference model through a queue

`timescale 1ns/1ns

`include "fma_settings.svh"

module fmaSumNormTb;
   import fmaPkg::*;

   localparam int W = `FMA_SUM_WIDTH;
   localparam int AW = `FMA_ADDEND_WIDTH;
   localparam int RANDOM_ITEMS = 400;
   localparam int DRAIN_LIMIT = 20;

   logic clk;
   logic reset;
   logic inValid;
   addendT addend;
   productT product;
   logic sub;

   logic outValid;
   sumT mantissa;
   shiftCntT normCount;
   logic negative;
   logic zero;

   integer seed;
   int cycleCount = 0;

   // Expected results in issue order, one entry per item in flight
   sumT expMant [$];
   shiftCntT expCnt [$];
   logic expNeg [$];
   logic expZero [$];
   // Rising edge at which a consumer must first see the item's outValid
   int expEdge [$];

   fmaSumNorm DUT (
      .clk(clk),
      .reset(reset),
      .inValid(inValid),
      .addend(addend),
      .product(product),
      .sub(sub),
      .outValid(outValid),
      .mantissa(mantissa),
      .normCount(normCount),
      .negative(negative),
      .zero(zero)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
   end

   //////////////////////////////////////////////////
   // Error reporting
   //////////////////////////////////////////////////

   task automatic reportMismatch(input string what);
      $display("Mismatch at %0t: %s", $time, what);
      $display("TEST FAIL");
      $fatal(1, "Stopped at the first wrong value");
   endtask

   task automatic reportFailure(input string what);
      $display("Error at %0t: %s", $time, what);
      $display("TEST FAIL");
      $fatal(1, "Stopped at the first failure");
   endtask

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   // Works from the arithmetic rules on a 64-bit integer, then cuts to the sum width
   task automatic pushExpected(input addendT a, input productT p, input logic s);
      addendT aPrep;
      logic [63:0] total;
      sumT sumV;
      sumT magV;
      int lead;
      bit found;
      aPrep = s ? ~a : a;
      // The subtract bit sits above the prepared addend, the carry-in is the subtract bit
      total = (64'(s) << AW) + 64'(aPrep) + 64'(p) + 64'(s);
      sumV = sumT'(total);
      magV = sumV[W-1] ? (~sumV + 1'b1) : sumV;
      lead = 0;
      found = 1'b0;
      for (int b = W - 1; b >= 0; b--) begin
         if (!found && !magV[b])
            lead++;
         else
            found = 1'b1;
      end
      expMant.push_back((magV == '0) ? sumT'(0) : (magV << lead));
      expCnt.push_back(shiftCntT'(lead));
      expNeg.push_back(sumV[W-1]);
      expZero.push_back(magV == '0);
      // Sampled at the next edge, so visible to a consumer two edges after that
      expEdge.push_back(cycleCount + 3);
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   task automatic sendItem(input addendT a, input productT p, input logic s);
      @(posedge clk);
      #1;
      inValid = 1'b1;
      addend = a;
      product = p;
      sub = s;
      pushExpected(a, p, s);
   endtask

   // Payload keeps moving while idle, the DUT must ignore it
   task automatic idleCycle();
      @(posedge clk);
      #1;
      inValid = 1'b0;
      addend = addendT'({$random(seed), $random(seed)});
      product = productT'($random(seed));
      sub = 1'($random(seed));
   endtask

   //////////////////////////////////////////////////
   // Output checks
   //////////////////////////////////////////////////

   task automatic checkHead();
      sumT m;
      shiftCntT c;
      logic n;
      logic z;
      int e;
      m = expMant.pop_front();
      c = expCnt.pop_front();
      n = expNeg.pop_front();
      z = expZero.pop_front();
      e = expEdge.pop_front();
      assert (cycleCount + 1 == e)
         else reportMismatch($sformatf("output at edge %0d, expected edge %0d", cycleCount + 1, e));
      assert (zero === z) else reportMismatch($sformatf("zero %b, expected %b", zero, z));
      assert (negative === n) else reportMismatch($sformatf("negative %b, expected %b", negative, n));
      assert (mantissa === m) else reportMismatch($sformatf("mantissa %h, expected %h", mantissa, m));
      // The count of a zero magnitude is not defined
      if (!z) begin
         assert (normCount === c)
            else reportMismatch($sformatf("normCount %0d, expected %0d", normCount, c));
      end
   endtask

   // Sampled on the falling edge, halfway between register updates
   always @(negedge clk) begin
      if (!reset) begin
         if (outValid) begin
            assert (expMant.size() != 0) else reportFailure("output strobe with no item in flight");
            checkHead();
         end else if (expEdge.size() != 0) begin
            assert (cycleCount + 1 != expEdge[0]) else reportFailure("an expected output never came");
         end
      end
   end

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      addendT a;
      addendT top;
      productT p;
      logic s;
      int cls;
      int drainWait;
      seed = 32'heaf0bb09;
      clk = 1'b0;
      reset = 1'b1;
      inValid = 1'b0;
      addend = '0;
      product = '0;
      sub = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      reset = 1'b0;

      // Idle stretch, any strobe here trips the checker since nothing is in flight
      repeat (12) idleCycle();

      // Exact cancellation
      for (int i = 0; i < 6; i++) begin
         p = productT'($random(seed));
         sendItem(addendT'(p), p, 1'b1);
      end
      idleCycle();

      // Subtraction with the product both above and below the addend
      for (int i = 0; i < 20; i++) begin
         p = productT'($random(seed));
         a = addendT'(productT'($random(seed)));
         sendItem(a, p, 1'b1);
      end

      // Sweep of the leading one over every bit, back to back
      // The sum's top bit is the sign, so a magnitude always has at least one leading zero
      for (int t = 1; t < W; t++) begin
         top = addendT'(1) << (W - 1 - t);
         a = top | (addendT'({$random(seed), $random(seed)}) & (top - 1'b1));
         sendItem(a, '0, 1'b0);
         sendItem(a, '0, 1'b1);
      end
      idleCycle();

      // Random mix with sparse idle cycles
      for (int i = 0; i < RANDOM_ITEMS; i++) begin
         cls = $unsigned($random(seed)) % 8;
         p = productT'($random(seed));
         s = 1'($random(seed));
         case (cls)
            3: a = addendT'($unsigned($random(seed))) << 12;
            4: a = addendT'($unsigned($random(seed)) >> 22);
            5: a = addendT'(p);
            6, 7: a = addendT'(productT'($random(seed)));
            default: a = addendT'({$random(seed), $random(seed)});
         endcase
         if (cls == 5 || cls == 6)
            s = 1'b1;
         // An addition that carried into the sign bit would read as negative
         if (!s)
            a[AW-1] = 1'b0;
         if (cls == 0)
            idleCycle();
         else
            sendItem(a, p, s);
      end
      idleCycle();

      drainWait = 0;
      while (expMant.size() != 0 && drainWait < DRAIN_LIMIT) begin
         @(negedge clk);
         drainWait++;
      end
      #1;
      if (expMant.size() != 0) begin
         $display("Error: timed out with %0d results still outstanding", expMant.size());
         $display("TEST FAIL");
         $fatal(1, "Pipeline did not drain");
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

// File: rtl/fmaSumNorm.sv
// FMA sum and normalize slice
// Two-stage pipeline from addend and product to a normalized magnitude

`timescale 1ns/1ns

module fmaSumNorm (
   input  logic              clk,
   input  logic              reset,

   // Operand side
   input  logic              inValid,
   input  fmaPkg::addendT    addend,
   input  fmaPkg::productT   product,
   input  logic              sub,

   // Result side, two cycles after the matching inValid
   output logic              outValid,
   output fmaPkg::sumT       mantissa,
   output fmaPkg::shiftCntT  normCount,
   output logic              negative,
   output logic              zero
);
   import fmaPkg::*;

   //////////////////////////////////////////////////
   // Stage link
   //////////////////////////////////////////////////

   // Registered magnitude, sign and anticipated count between the stages
   normStageIf stageLink ();

   //////////////////////////////////////////////////
   // Stage one
   //////////////////////////////////////////////////

   // Add, magnitude and leading-zero anticipation
   sumStage sumPart (
      .clk(clk),
      .reset(reset),
      .inValid(inValid),
      .addend(addend),
      .product(product),
      .sub(sub),
      .toNorm(stageLink.source)
   );

   //////////////////////////////////////////////////
   // Stage two
   //////////////////////////////////////////////////

   // Normalizing shift with the one-bit correction
   normShift normPart (
      .clk(clk),
      .reset(reset),
      .fromSum(stageLink.sink),
      .outValid(outValid),
      .mantissa(mantissa),
      .normCount(normCount),
      .negative(negative),
      .zero(zero)
   );

endmodule

// File: rtl/normShift.sv
// FMA normalize stage
// Shifts the magnitude by the anticipated count and fixes a one-place shortfall

`timescale 1ns/1ns

module normShift (
   input  logic              clk,
   input  logic              reset,
   normStageIf.sink          fromSum,
   output logic              outValid,
   output fmaPkg::sumT       mantissa,
   output fmaPkg::shiftCntT  normCount,
   output logic              negative,
   output logic              zero
);
   import fmaPkg::*;

   localparam int W = $bits(sumT);

   // Result of the anticipated shift and of the corrected shift
   sumT coarse;
   sumT fine;

   // Set when the anticipator came up one place short
   logic short;

   shiftCntT trueCnt;
   logic magZero;

   //////////////////////////////////////////////////
   // Normalization shift
   //////////////////////////////////////////////////

   // The anticipated count never overshoots, so this shift never drops a one
   assign coarse = fromSum.mag << fromSum.aCnt;

   // A clear top bit means the leading one sits one place lower
   assign short = ~coarse[W-1];

   // One-bit correction shift
   assign fine = short ? {coarse[W-2:0], 1'b0} : coarse;

   // Reported count is the true leading-zero count of the magnitude
   assign trueCnt = fromSum.aCnt + shiftCntT'(short);

   //////////////////////////////////////////////////
   // Zero detection
   //////////////////////////////////////////////////

   // Checked on the magnitude itself and not on the shifted value
   assign magZero = (fromSum.mag == '0);

   //////////////////////////////////////////////////
   // Output register
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         outValid <= 1'b0;
      end else begin
         outValid <= fromSum.valid;
      end
   end

   // Every valid item is taken since there is no back-pressure
   always_ff @(posedge clk) begin
      if (fromSum.valid) begin
         // A zero magnitude shifts to an all-zero result by itself
         mantissa <= fine;
         normCount <= trueCnt;
         negative <= fromSum.sign;
         zero <= magZero;
      end
   end

endmodule

// File: rtl/sumStage.sv
// FMA sum stage
// Adds or subtracts the addend, takes the magnitude and anticipates its leading zeros

`timescale 1ns/1ns

module sumStage (
   input  logic             clk,
   input  logic             reset,
   input  logic             inValid,
   input  fmaPkg::addendT   addend,
   input  fmaPkg::productT  product,
   input  logic             sub,
   normStageIf.source       toNorm
);
   import fmaPkg::*;

   localparam int W = $bits(sumT);

   // Operands shared by the adder and the anticipator
   lzaOperandsIf lzaOps ();

   // Full two's complement sum and its absolute value
   sumT sum;
   sumT mag;
   logic sign;

   // Shift count from the anticipator
   shiftCntT aCnt;

   //////////////////////////////////////////////////
   // Operand preparation
   //////////////////////////////////////////////////

   // Subtraction uses the inverted addend plus one
   assign lzaOps.aPrep = sub ? ~addend : addend;

   // Product zero-extended up to the addend width
   assign lzaOps.prodExt = addendT'(product);

   assign lzaOps.carryIn = sub;
   assign lzaOps.sub = sub;

   //////////////////////////////////////////////////
   // Adder and magnitude
   //////////////////////////////////////////////////

   // The subtract bit extends the inverted addend, so the top bit becomes the sign
   assign sum = {lzaOps.sub, lzaOps.aPrep} + sumT'(lzaOps.prodExt) + sumT'(lzaOps.carryIn);

   assign sign = sum[W-1];

   // A negative result is negated back to a magnitude
   // It can never reach the most negative value, so the negation is exact
   assign mag = sign ? -sum : sum;

   //////////////////////////////////////////////////
   // Leading-zero anticipation
   //////////////////////////////////////////////////

   // Runs beside the adder on the same prepared operands
   fmaLza anticipator (
      .ops(lzaOps.sink),
      .sCnt(aCnt)
   );

   //////////////////////////////////////////////////
   // Stage register
   //////////////////////////////////////////////////

   // Valid follows the input strobe by one cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         toNorm.valid <= 1'b0;
      end else begin
         toNorm.valid <= inValid;
      end
   end

   // Payload loads only with a valid item and holds otherwise
   always_ff @(posedge clk) begin
      if (inValid) begin
         toNorm.mag <= mag;
         toNorm.sign <= sign;
         toNorm.aCnt <= aCnt;
      end
   end

endmodule

// File: rtl/fmaLza.sv
// Leading-zero anticipator for the FMA sum
// Predicts the normalization shift from the operands while the adder runs

`timescale 1ns/1ns

module fmaLza (
   lzaOperandsIf.sink ops,
   output fmaPkg::shiftCntT sCnt
);
   import fmaPkg::*;

   localparam int W = $bits(sumT);

   // Leading indicator string, one bit per sum position
   sumT f;

   // Propagate, generate and kill over the addend positions
   addendT p;
   addendT g;
   addendT k;

   // Neighbour strings, the one above and the one below each position
   addendT pUp;
   addendT gDn;
   addendT kDn;

   //////////////////////////////////////////////////
   // Bitwise operand strings
   //////////////////////////////////////////////////

   assign p = ops.aPrep ^ ops.prodExt;
   assign g = ops.aPrep & ops.prodExt;
   assign k = ~ops.aPrep & ~ops.prodExt;

   // Above the top addend bit sits the extension bit of the sum, which is the subtract bit
   assign pUp = {ops.sub, p[W-2:1]};

   // Below the bottom bit the carry-in acts as a generate, its absence as a kill
   assign gDn = {g[W-3:0], ops.carryIn};
   assign kDn = {k[W-3:0], ~ops.carryIn};

   //////////////////////////////////////////////////
   // Indicator string
   //////////////////////////////////////////////////

   // Top position fires when an addition propagates into the extension bit
   assign f[W-1] = ~ops.sub & p[W-2];

   // A position fires where the sum stops repeating its sign, so the first set bit
   // lands on the leading digit of the magnitude or one place above it
   // The bottom position also takes the sum's own bottom bit, which catches a
   // magnitude of one that the neighbour strings miss at the lower edge
   assign f[W-2:0] = (pUp & ((g & ~kDn) | (k & ~gDn))) |
                     (~pUp & ((k & ~kDn) | (g & ~gDn))) |
                     addendT'(p[0] ^ ops.carryIn);

   //////////////////////////////////////////////////
   // Count
   //////////////////////////////////////////////////

   // Leading zeros of f give the anticipated shift
   lzc #(
      .WIDTH(W)
   ) indicatorCount (
      .num(f),
      .zeroCnt(sCnt)
   );

endmodule

// File: rtl/lzc.sv
// Leading-zero counter
// Binary priority tree over a power-of-two padded input

`timescale 1ns/1ns

`include "fma_settings.svh"

module lzc #(
   parameter int WIDTH = `FMA_SUM_WIDTH
) (
   input  logic [WIDTH-1:0]         num,
   output logic [$clog2(WIDTH)-1:0] zeroCnt
);

   localparam int CW = $clog2(WIDTH);
   // Tree leaves, rounded up to a power of two
   localparam int P = 1 << CW;

   logic [P-1:0] padded;
   // Per level, a node is valid when its subtree holds a one
   logic vld [CW+1][P];
   logic [CW-1:0] cnt [CW+1][P];

   // Padding goes below the input so it never wins over a real one
   assign padded = P'(num) << (P - WIDTH);

   always_comb begin
      // Leaf i sees bit i counted from the top
      for (int i = 0; i < P; i++) begin
         vld[0][i] = padded[P-1-i];
         cnt[0][i] = '0;
      end
      // Each level merges pairs, the left child being more significant
      for (int l = 0; l < CW; l++) begin
         for (int j = 0; j < P; j++) begin
            if (j < (P >> (l + 1))) begin
               vld[l+1][j] = vld[l][2*j] | vld[l][2*j+1];
               // An empty left half adds its full 2**l zeros to the right count
               cnt[l+1][j] = vld[l][2*j] ? cnt[l][2*j] : (cnt[l][2*j+1] | CW'(1 << l));
            end else begin
               vld[l+1][j] = 1'b0;
               cnt[l+1][j] = '0;
            end
         end
      end
   end

   // All-zero input reports WIDTH, cut to the port width
   assign zeroCnt = vld[CW][0] ? cnt[CW][0] : CW'(WIDTH);

endmodule

// File: rtl/fmaIfs.sv
// FMA sum and normalize interfaces
// Operand bundle for the anticipator and the link between the two stages

`timescale 1ns/1ns

//////////////////////////////////////////////////
// Prepared operands for the leading-zero anticipator
//////////////////////////////////////////////////

// Purely combinational, sampled in the same cycle as the adder
interface lzaOperandsIf;
   import fmaPkg::*;

   // Addend after the optional inversion for subtraction
   addendT aPrep;
   // Product zero-extended to the addend width
   addendT prodExt;
   // Carry into the bottom bit, set for two's complement subtraction
   logic carryIn;
   // Effective subtraction
   logic sub;

   modport source (output aPrep, prodExt, carryIn, sub);
   modport sink (input aPrep, prodExt, carryIn, sub);
endinterface

//////////////////////////////////////////////////
// Stage one to stage two register link
//////////////////////////////////////////////////

// Valid is high for exactly one cycle per item, with no back-pressure
interface normStageIf;
   import fmaPkg::*;

   logic valid;
   // Absolute value of the sum
   sumT mag;
   // Sign of the two's complement sum
   logic sign;
   // Anticipated leading-zero count, exact or one short
   shiftCntT aCnt;

   modport source (output valid, mag, sign, aCnt);
   modport sink (input valid, mag, sign, aCnt);
endinterface

// File: rtl/fmaPkg.sv
// FMA sum and normalize types
// Vector types shared by the stages and their interfaces

`include "fma_settings.svh"

package fmaPkg;

   //////////////////////////////////////////////////
   // Datapath vectors
   //////////////////////////////////////////////////

   // Aligned addend as delivered by the alignment shifter
   typedef logic [`FMA_ADDEND_WIDTH-1:0] addendT;

   // Product mantissa from the multiplier array
   typedef logic [`FMA_PRODUCT_WIDTH-1:0] productT;

   // Sum, magnitude and normalized result all share this width
   typedef logic [`FMA_SUM_WIDTH-1:0] sumT;

   // Anticipated or true normalization shift
   typedef logic [`FMA_CNT_WIDTH-1:0] shiftCntT;

endpackage

// File: include/fma_settings.svh
// FMA sum and normalize slice settings
// Fraction width and the datapath widths derived from it

`ifndef FMA_SETTINGS_SVH
`define FMA_SETTINGS_SVH

// Stored fraction width of the format
`define FMA_NF 10

// Sum and anticipator width, wide enough for the aligned addend plus carry room
`define FMA_SUM_WIDTH (3*`FMA_NF+7)

// The aligned addend is one bit short of the sum
`define FMA_ADDEND_WIDTH (`FMA_SUM_WIDTH-1)

// Product of two significands with guard room
`define FMA_PRODUCT_WIDTH (2*`FMA_NF+4)

// Width of a leading-zero or shift count over the sum
`define FMA_CNT_WIDTH ($clog2(`FMA_SUM_WIDTH))

`endif
